//--- rtl/term_pkg.sv
package term_pkg;

  // character grid and glyph cell size
  localparam int COLS = 80;
  localparam int ROWS = 30;
  localparam int CELLS = 2400;
  localparam int CELL_W = 8;
  localparam int CELL_H = 16;

  // 640x480 timing, both syncs active low
  localparam int H_ACTIVE = 640;
  localparam int H_FP = 16;
  localparam int H_SYNC = 96;
  localparam int H_BP = 48;
  localparam int H_TOTAL = 800;
  localparam int V_ACTIVE = 480;
  localparam int V_FP = 10;
  localparam int V_SYNC = 2;
  localparam int V_BP = 33;
  localparam int V_TOTAL = 525;

  localparam logic [7:0] SC_BREAK = 8'hf0;
  localparam logic [7:0] SC_EXT = 8'he0;
  localparam logic [7:0] SC_ENTER = 8'h5a;
  localparam logic [7:0] SC_BKSP = 8'h66;
  localparam logic [7:0] CH_SPACE = 8'h20;

  typedef enum logic [1:0] {
    KEY_PRINT,
    KEY_NEWLINE,
    KEY_BKSP
  } key_kind_t;

  typedef struct packed {
    logic       valid;
    key_kind_t  kind;
    logic [7:0] ascii;
  } key_event_t;

  typedef struct packed {
    logic [9:0] h;
    logic [9:0] v;
    logic       active;
  } vga_pos_t;

  typedef struct packed {
    logic hsync;
    logic vsync;
    logic blank_n;
  } vga_sync_t;

  // set 2 make codes, 0 means no printable character
  function automatic logic [7:0] scan_to_ascii(input logic [7:0] code);
    logic [7:0] ch;
    case (code)
      8'h1c: ch = "a";
      8'h32: ch = "b";
      8'h21: ch = "c";
      8'h23: ch = "d";
      8'h24: ch = "e";
      8'h2b: ch = "f";
      8'h34: ch = "g";
      8'h33: ch = "h";
      8'h43: ch = "i";
      8'h3b: ch = "j";
      8'h42: ch = "k";
      8'h4b: ch = "l";
      8'h3a: ch = "m";
      8'h31: ch = "n";
      8'h44: ch = "o";
      8'h4d: ch = "p";
      8'h15: ch = "q";
      8'h2d: ch = "r";
      8'h1b: ch = "s";
      8'h2c: ch = "t";
      8'h3c: ch = "u";
      8'h2a: ch = "v";
      8'h1d: ch = "w";
      8'h22: ch = "x";
      8'h35: ch = "y";
      8'h1a: ch = "z";
      8'h45: ch = "0";
      8'h16: ch = "1";
      8'h1e: ch = "2";
      8'h26: ch = "3";
      8'h25: ch = "4";
      8'h2e: ch = "5";
      8'h36: ch = "6";
      8'h3d: ch = "7";
      8'h3e: ch = "8";
      8'h46: ch = "9";
      8'h29: ch = CH_SPACE;
      default: ch = 8'h00;
    endcase
    return ch;
  endfunction

endpackage

//--- rtl/ps2_rx.sv
`timescale 1ns/100ps

module ps2_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic [7:0] rx_byte,
  output logic       rx_strobe
);

  // [0] meta, [1] synced, [2] previous synced value
  logic [2:0] ps2_clk_q;
  logic [1:0] ps2_data_q;
  logic       clk_fall;
  logic       data_s;
  logic [3:0] bit_cnt;
  logic [9:0] shreg;
  logic       frame_ok;

  assign clk_fall = ps2_clk_q[2] & ~ps2_clk_q[1];
  assign data_s = ps2_data_q[1];

  // shreg[0] start, shreg[8:1] data, shreg[9] parity, data_s is the stop bit
  assign frame_ok = ~shreg[0] & data_s & (^shreg[9:1]);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ps2_clk_q <= 3'b111;
      ps2_data_q <= 2'b11;
    end else begin
      ps2_clk_q <= {ps2_clk_q[1:0], ps2_clk};
      ps2_data_q <= {ps2_data_q[0], ps2_data};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_cnt <= 4'd0;
      rx_strobe <= 1'b0;
    end else begin
      rx_strobe <= 1'b0;
      if (clk_fall) begin
        if (bit_cnt == 4'd10) begin
          bit_cnt <= 4'd0;
          rx_strobe <= frame_ok;
        end else if (bit_cnt != 4'd0 || !data_s) begin
          // wait for a low start bit before counting
          bit_cnt <= bit_cnt + 4'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clk_fall && bit_cnt != 4'd10) begin
      shreg <= {data_s, shreg[9:1]};
    end
    if (clk_fall && bit_cnt == 4'd10 && frame_ok) begin
      rx_byte <= shreg[8:1];
    end
  end

endmodule

//--- rtl/key_decoder.sv
`timescale 1ns/100ps

module key_decoder (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [7:0]           rx_byte,
  input  logic                 rx_strobe,
  output term_pkg::key_event_t key_event
);

  logic                br_flag;
  logic [7:0]          mapped;
  logic                next_valid;
  term_pkg::key_kind_t next_kind;
  logic                valid_q;
  term_pkg::key_kind_t kind_q;
  logic [7:0]          ascii_q;

  always_comb begin
    mapped = term_pkg::scan_to_ascii(rx_byte);
    next_kind = term_pkg::KEY_PRINT;
    next_valid = (mapped != 8'h00);
    if (rx_byte == term_pkg::SC_ENTER) begin
      next_kind = term_pkg::KEY_NEWLINE;
      next_valid = 1'b1;
    end else if (rx_byte == term_pkg::SC_BKSP) begin
      next_kind = term_pkg::KEY_BKSP;
      next_valid = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      br_flag <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (rx_strobe) begin
        if (rx_byte == term_pkg::SC_BREAK) begin
          br_flag <= 1'b1;
        end else if (br_flag) begin
          // released key code, swallowed
          br_flag <= 1'b0;
        end else if (rx_byte != term_pkg::SC_EXT) begin
          valid_q <= next_valid;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_strobe) begin
      kind_q <= next_kind;
      ascii_q <= mapped;
    end
  end

  assign key_event = '{valid: valid_q, kind: kind_q, ascii: ascii_q};

endmodule

//--- rtl/text_buffer.sv
`timescale 1ns/100ps

module text_buffer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  term_pkg::key_event_t key_event,
  input  logic [11:0]          rd_addr,
  output logic [7:0]           rd_char
);

  logic [7:0]  grid [term_pkg::CELLS];
  logic [4:0]  cur_row;
  logic [6:0]  cur_col;
  logic [11:0] cur_addr;
  logic [11:0] clr_cnt;
  logic        clearing;
  logic        at_home;
  logic        last_col;
  logic        last_row;
  logic        wr_en;
  logic [11:0] wr_addr;
  logic [7:0]  wr_data;

  // row * 80 as row * 64 + row * 16
  assign cur_addr = {1'b0, cur_row, 6'b0} + {3'b0, cur_row, 4'b0} + {5'b0, cur_col};
  assign at_home = (cur_row == 5'd0) && (cur_col == 7'd0);
  assign last_col = (cur_col == 7'(term_pkg::COLS - 1));
  assign last_row = (cur_row == 5'(term_pkg::ROWS - 1));

  always_comb begin
    wr_en = 1'b0;
    wr_addr = cur_addr;
    wr_data = key_event.ascii;
    if (clearing) begin
      wr_en = 1'b1;
      wr_addr = clr_cnt;
      wr_data = term_pkg::CH_SPACE;
    end else if (key_event.valid) begin
      case (key_event.kind)
        term_pkg::KEY_PRINT: wr_en = 1'b1;
        term_pkg::KEY_BKSP: begin
          wr_en = !at_home;
          wr_addr = cur_addr - 12'd1;
          wr_data = term_pkg::CH_SPACE;
        end
        default: wr_en = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      grid[wr_addr] <= wr_data;
    end
    rd_char <= clearing ? term_pkg::CH_SPACE : grid[rd_addr];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clearing <= 1'b1;
      clr_cnt <= 12'd0;
      cur_row <= 5'd0;
      cur_col <= 7'd0;
    end else if (clearing) begin
      clr_cnt <= clr_cnt + 12'd1;
      if (clr_cnt == 12'(term_pkg::CELLS - 1)) begin
        clearing <= 1'b0;
      end
    end else if (key_event.valid) begin
      case (key_event.kind)
        term_pkg::KEY_PRINT: begin
          cur_col <= last_col ? 7'd0 : cur_col + 7'd1;
          if (last_col) begin
            cur_row <= last_row ? 5'd0 : cur_row + 5'd1;
          end
        end
        term_pkg::KEY_NEWLINE: begin
          cur_col <= 7'd0;
          cur_row <= last_row ? 5'd0 : cur_row + 5'd1;
        end
        term_pkg::KEY_BKSP: begin
          if (cur_col != 7'd0) begin
            cur_col <= cur_col - 7'd1;
          end else if (!at_home) begin
            cur_col <= 7'(term_pkg::COLS - 1);
            cur_row <= cur_row - 5'd1;
          end
        end
        default: cur_col <= cur_col;
      endcase
    end
  end

endmodule

//--- rtl/vga_timing.sv
`timescale 1ns/100ps

module vga_timing (
  input  logic                clk,
  input  logic                rst_n,
  output term_pkg::vga_pos_t  pos,
  output term_pkg::vga_sync_t sync
);

  logic [9:0] h_cnt;
  logic [9:0] v_cnt;
  logic       active;
  logic       h_in_sync;
  logic       v_in_sync;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt <= 10'd0;
      v_cnt <= 10'd0;
    end else if (h_cnt == 10'(term_pkg::H_TOTAL - 1)) begin
      h_cnt <= 10'd0;
      if (v_cnt == 10'(term_pkg::V_TOTAL - 1)) begin
        v_cnt <= 10'd0;
      end else begin
        v_cnt <= v_cnt + 10'd1;
      end
    end else begin
      h_cnt <= h_cnt + 10'd1;
    end
  end

  assign active = (h_cnt < 10'(term_pkg::H_ACTIVE)) && (v_cnt < 10'(term_pkg::V_ACTIVE));

  // sync windows start after the front porch
  assign h_in_sync = (h_cnt >= 10'(term_pkg::H_ACTIVE + term_pkg::H_FP)) &&
                     (h_cnt < 10'(term_pkg::H_ACTIVE + term_pkg::H_FP + term_pkg::H_SYNC));
  assign v_in_sync = (v_cnt >= 10'(term_pkg::V_ACTIVE + term_pkg::V_FP)) &&
                     (v_cnt < 10'(term_pkg::V_ACTIVE + term_pkg::V_FP + term_pkg::V_SYNC));

  assign pos = '{h: h_cnt, v: v_cnt, active: active};
  assign sync = '{hsync: !h_in_sync, vsync: !v_in_sync, blank_n: active};

endmodule

//--- rtl/glyph_render.sv
`timescale 1ns/100ps

module glyph_render (
  input  logic                clk,
  input  logic                rst_n,
  input  term_pkg::vga_pos_t  pos,
  input  term_pkg::vga_sync_t sync,
  output logic [11:0]         rd_addr,
  input  logic [7:0]          rd_char,
  output logic [11:0]         font_addr,
  input  logic [7:0]          font_row,
  output term_pkg::vga_sync_t pix_sync,
  output logic [7:0]          vga_r,
  output logic [7:0]          vga_g,
  output logic [7:0]          vga_b
);

  logic [4:0]          cell_row;
  logic [6:0]          cell_col;
  logic [3:0]          s1_row;
  logic [2:0]          s1_col;
  logic                s1_active;
  term_pkg::vga_sync_t s1_sync;
  logic                pix_on;

  assign cell_row = pos.v[8:4];
  assign cell_col = pos.h[9:3];

  // blanking positions read cell 0 so the index stays inside the grid
  assign rd_addr = pos.active ?
    ({1'b0, cell_row, 6'b0} + {3'b0, cell_row, 4'b0} + {5'b0, cell_col}) : 12'd0;

  always_ff @(posedge clk) begin
    s1_row <= pos.v[3:0];
    s1_col <= pos.h[2:0];
  end

  assign font_addr = {rd_char, s1_row};

  // bit 7 of the glyph row is the leftmost pixel
  assign pix_on = font_row[3'd7 - s1_col] & s1_active;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_active <= 1'b0;
      s1_sync <= '{hsync: 1'b1, vsync: 1'b1, blank_n: 1'b0};
      pix_sync <= '{hsync: 1'b1, vsync: 1'b1, blank_n: 1'b0};
      vga_r <= 8'd0;
      vga_g <= 8'd0;
      vga_b <= 8'd0;
    end else begin
      s1_active <= pos.active;
      s1_sync <= sync;
      pix_sync <= s1_sync;
      vga_r <= {8{pix_on}};
      vga_g <= {8{pix_on}};
      vga_b <= {8{pix_on}};
    end
  end

endmodule

//--- rtl/kbd_vga_term.sv
`timescale 1ns/100ps

module kbd_vga_term (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        ps2_clk,
  input  logic        ps2_data,
  input  logic [7:0]  font_row,
  output logic [11:0] font_addr,
  output logic        vga_hsync,
  output logic        vga_vsync,
  output logic        vga_blank_n,
  output logic [7:0]  vga_r,
  output logic [7:0]  vga_g,
  output logic [7:0]  vga_b
);

  logic [7:0]           rx_byte;
  logic                 rx_strobe;
  term_pkg::key_event_t key_event;
  term_pkg::vga_pos_t   pos;
  term_pkg::vga_sync_t  sync;
  term_pkg::vga_sync_t  pix_sync;
  logic [11:0]          rd_addr;
  logic [7:0]           rd_char;

  ps2_rx u_ps2_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .ps2_clk   (ps2_clk),
    .ps2_data  (ps2_data),
    .rx_byte   (rx_byte),
    .rx_strobe (rx_strobe)
  );

  key_decoder u_key_decoder (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_byte   (rx_byte),
    .rx_strobe (rx_strobe),
    .key_event (key_event)
  );

  text_buffer u_text_buffer (
    .clk       (clk),
    .rst_n     (rst_n),
    .key_event (key_event),
    .rd_addr   (rd_addr),
    .rd_char   (rd_char)
  );

  vga_timing u_vga_timing (
    .clk   (clk),
    .rst_n (rst_n),
    .pos   (pos),
    .sync  (sync)
  );

  glyph_render u_glyph_render (
    .clk       (clk),
    .rst_n     (rst_n),
    .pos       (pos),
    .sync      (sync),
    .rd_addr   (rd_addr),
    .rd_char   (rd_char),
    .font_addr (font_addr),
    .font_row  (font_row),
    .pix_sync  (pix_sync),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b)
  );

  assign vga_hsync = pix_sync.hsync;
  assign vga_vsync = pix_sync.vsync;
  assign vga_blank_n = pix_sync.blank_n;

endmodule

//--- testbench/kbd_vga_term_asserts.sv
`timescale 1ns/100ps

module kbd_vga_term_asserts (
  input logic       clk,
  input logic       rst_n,
  input logic       vga_hsync,
  input logic       vga_vsync,
  input logic       vga_blank_n,
  input logic [7:0] vga_r,
  input logic [7:0] vga_g,
  input logic [7:0] vga_b,
  input logic       key_valid
);

  logic [9:0] hs_low_cnt;

  // number of assertion failures so far
  int fail_cnt = 0;

  // length of the current hsync low pulse
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hs_low_cnt <= 10'd0;
    end else if (!vga_hsync) begin
      hs_low_cnt <= hs_low_cnt + 10'd1;
    end else begin
      hs_low_cnt <= 10'd0;
    end
  end

  a_black_in_blank: assert property (@(posedge clk) disable iff (!rst_n)
    !vga_blank_n |-> (vga_r == 8'd0 && vga_g == 8'd0 && vga_b == 8'd0))
    else begin
      $error("rgb is not black while blanked");
      fail_cnt++;
    end

  a_blank_in_sync: assert property (@(posedge clk) disable iff (!rst_n)
    (!vga_hsync || !vga_vsync) |-> !vga_blank_n)
    else begin
      $error("vga_blank_n high during a sync pulse");
      fail_cnt++;
    end

  a_hsync_width: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(vga_hsync) |-> (hs_low_cnt == 10'(term_pkg::H_SYNC)))
    else begin
      $error("hsync low pulse has the wrong length");
      fail_cnt++;
    end

  a_key_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    key_valid |=> !key_valid)
    else begin
      $error("key event valid held for more than one cycle");
      fail_cnt++;
    end

endmodule

bind kbd_vga_term kbd_vga_term_asserts u_asserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .vga_hsync   (vga_hsync),
  .vga_vsync   (vga_vsync),
  .vga_blank_n (vga_blank_n),
  .vga_r       (vga_r),
  .vga_g       (vga_g),
  .vga_b       (vga_b),
  .key_valid   (key_event.valid)
);

//--- testbench/tb_kbd_vga_term.sv
`timescale 1ns/100ps

module tb_kbd_vga_term;

  logic        clk;
  logic        rst_n;
  logic        ps2_clk;
  logic        ps2_data;
  logic [7:0]  font_row;
  logic [11:0] font_addr;
  logic        vga_hsync;
  logic        vga_vsync;
  logic        vga_blank_n;
  logic [7:0]  vga_r;
  logic [7:0]  vga_g;
  logic [7:0]  vga_b;

  int stim [1024];
  int grid_model [$];
  int cursor;
  int cyc = 0;
  int last_hs_fall;
  int mismatches;
  int timeouts;

  kbd_vga_term DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .font_row    (font_row),
    .font_addr   (font_addr),
    .vga_hsync   (vga_hsync),
    .vga_vsync   (vga_vsync),
    .vga_blank_n (vga_blank_n),
    .vga_r       (vga_r),
    .vga_g       (vga_g),
    .vga_b       (vga_b)
  );

  // font ROM model, ascii xor (glyph row * 17)
  assign font_row = font_addr[11:4] ^ ({4'd0, font_addr[3:0]} * 8'd17);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task ps2_bit(input logic val);
    ps2_data = val;
    repeat (4) @(negedge clk);
    ps2_clk = 1'b0;
    repeat (4) @(negedge clk);
    ps2_clk = 1'b1;
  endtask

  task send_ps2_byte(input int code, input int bad);
    logic [7:0] b;
    logic       par;
    int         i;
    b = 8'(code);
    par = ~(^b) ^ (bad != 0);
    ps2_bit(1'b0);
    for (i = 0; i < 8; i++) begin
      ps2_bit(b[0]);
      b = b >> 1;
    end
    ps2_bit(par);
    ps2_bit(1'b1);
    repeat (4 + $urandom % 40) @(negedge clk);
  endtask

  task apply_effect(input int effect);
    case (effect)
      0: begin
      end
      'h08: begin
        if (cursor != 0) begin
          cursor--;
          grid_model[cursor] = 'h20;
        end
      end
      'h0a: cursor = ((cursor / term_pkg::COLS + 1) % term_pkg::ROWS) * term_pkg::COLS;
      default: begin
        grid_model[cursor] = effect;
        cursor = (cursor + 1) % term_pkg::CELLS;
      end
    endcase
  endtask

  task wait_hsync_fall();
    int n;
    n = 0;
    if (timeouts == 0) begin
      while (!vga_hsync && n < 2 * term_pkg::H_TOTAL) begin
        @(negedge clk);
        n++;
      end
      while (vga_hsync && n < 2 * term_pkg::H_TOTAL) begin
        @(negedge clk);
        n++;
      end
      if (n >= 2 * term_pkg::H_TOTAL) begin
        $display("timeout waiting for a falling edge on vga_hsync");
        timeouts++;
      end else begin
        if (last_hs_fall >= 0 && cyc - last_hs_fall != term_pkg::H_TOTAL) begin
          $display("Mismatch at %0t: hsync period %0d", $time, cyc - last_hs_fall);
          mismatches++;
        end
        last_hs_fall = cyc;
      end
    end
  endtask

  task wait_vsync_fall();
    int n;
    n = 0;
    if (timeouts == 0) begin
      while (!vga_vsync && n < 2 * term_pkg::V_TOTAL * term_pkg::H_TOTAL) begin
        @(negedge clk);
        n++;
      end
      while (vga_vsync && n < 2 * term_pkg::V_TOTAL * term_pkg::H_TOTAL) begin
        @(negedge clk);
        n++;
      end
      if (n >= 2 * term_pkg::V_TOTAL * term_pkg::H_TOTAL) begin
        $display("timeout waiting for a falling edge on vga_vsync");
        timeouts++;
      end
      last_hs_fall = -1;
    end
  endtask

  task check_reset_outputs();
    int n;
    n = 0;
    while (!vga_blank_n && n < 100) begin
      if (!vga_hsync || !vga_vsync || vga_r != 8'd0 || vga_g != 8'd0 || vga_b != 8'd0) begin
        $display("Mismatch at %0t: outputs not idle before the first pixel", $time);
        mismatches++;
      end
      @(negedge clk);
      n++;
    end
    if (!vga_blank_n) begin
      $display("timeout waiting for vga_blank_n to go high after reset");
      timeouts++;
    end
  endtask

  task compare_frame();
    int         skip;
    int         line;
    int         px;
    int         n;
    int         vs_fall;
    logic [7:0] glyph;
    logic [7:0] exp_rgb;
    wait_vsync_fall();
    vs_fall = cyc;
    // the hsync fall on the last line of vertical blanking precedes line 0
    for (skip = 0; skip < term_pkg::V_TOTAL - term_pkg::V_ACTIVE - term_pkg::V_FP - 1;
         skip++) begin
      wait_hsync_fall();
    end
    for (line = 0; line < term_pkg::V_ACTIVE && timeouts == 0; line++) begin
      wait_hsync_fall();
      repeat (term_pkg::H_SYNC + term_pkg::H_BP - 1) @(negedge clk);
      if (vga_blank_n) begin
        $display("Mismatch at %0t: vga_blank_n high before pixel 0 of line %0d", $time, line);
        mismatches++;
      end
      @(negedge clk);
      for (px = 0; px < term_pkg::H_ACTIVE; px++) begin
        glyph = 8'(grid_model[(line / term_pkg::CELL_H) * term_pkg::COLS + px / term_pkg::CELL_W]);
        glyph = glyph ^ 8'((line % term_pkg::CELL_H) * 17);
        glyph = glyph << (px % term_pkg::CELL_W);
        exp_rgb = glyph[7] ? 8'hff : 8'h00;
        if (!vga_blank_n || vga_r != exp_rgb || vga_g != exp_rgb || vga_b != exp_rgb) begin
          $display("Mismatch at %0t: pixel (%0d,%0d) blank_n %b rgb %h %h %h, expected %h",
                   $time, px, line, vga_blank_n, vga_r, vga_g, vga_b, exp_rgb);
          mismatches++;
        end
        @(negedge clk);
      end
      if (vga_blank_n) begin
        $display("Mismatch at %0t: vga_blank_n still high after 640 pixels", $time);
        mismatches++;
      end
    end
    // count lines while vsync is low
    wait_vsync_fall();
    if (timeouts == 0 && cyc - vs_fall != term_pkg::V_TOTAL * term_pkg::H_TOTAL) begin
      $display("Mismatch at %0t: vsync period %0d cycles", $time, cyc - vs_fall);
      mismatches++;
    end
    n = 0;
    for (skip = 0; skip < 8 && timeouts == 0; skip++) begin
      wait_hsync_fall();
      if (vga_vsync) break;
      n++;
    end
    if (timeouts == 0 && n != term_pkg::V_SYNC) begin
      $display("Mismatch at %0t: vsync low for %0d lines", $time, n);
      mismatches++;
    end
  endtask

  initial begin
    int i;
    int rec;
    int rep;
    void'($urandom(61293));
    rst_n = 1'b0;
    ps2_clk = 1'b1;
    ps2_data = 1'b1;
    cursor = 0;
    last_hs_fall = -1;
    mismatches = 0;
    timeouts = 0;
    for (i = 0; i < 1024; i++) begin
      stim[10'(i)] = 32'hf000 + i;
    end
    $readmemh("testbench/key_input.txt", stim);
    for (i = 0; i < term_pkg::CELLS; i++) begin
      grid_model.push_back(int'(term_pkg::CH_SPACE));
    end
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    check_reset_outputs();
    // blank grid, the clear sweep is over well before the first full frame
    compare_frame();
    rec = 0;
    while (rec < 256 && stim[10'(rec * 4)] < 'h100 && timeouts == 0) begin
      for (rep = 0; rep < stim[10'(rec * 4 + 3)]; rep++) begin
        send_ps2_byte(stim[10'(rec * 4)], stim[10'(rec * 4 + 1)]);
        apply_effect(stim[10'(rec * 4 + 2)]);
      end
      rec++;
    end
    compare_frame();
    $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatches, timeouts, DUT.u_asserts.fail_cnt);
    if (mismatches == 0 && timeouts == 0 && DUT.u_asserts.fail_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- kbd_vga_term.f
rtl/term_pkg.sv
rtl/ps2_rx.sv
rtl/key_decoder.sv
rtl/text_buffer.sv
rtl/vga_timing.sv
rtl/glyph_render.sv
rtl/kbd_vga_term.sv
testbench/kbd_vga_term_asserts.sv
testbench/tb_kbd_vga_term.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_kbd_vga_term
FILELIST  = kbd_vga_term.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "PASS: all tests" $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/key_input.txt
// columns: scancode, bad parity flag, expected effect, repeat count
// effect 00 none, 08 backspace, 0a newline, anything else is the ascii written
66 00 08 01
33 00 68 01
24 00 65 01
29 00 20 01
16 00 31 01
45 00 30 01
f0 00 00 01
45 00 00 01
e0 00 00 01
75 00 00 01
05 00 00 01
1c 01 00 01
66 00 08 01
5a 00 0a 01
1a 00 7a 01
5a 00 0a 1c
3e 00 38 50
2b 00 66 01
